// ==== logic/adc_spi.sv ====
`timescale 1ns/1ns

module adc_spi (
	input  logic        CLK50MHZ,
	input  logic        RST,
	input  logic        adc_trig,
	output logic        adc_done,
	output logic [13:0] adc_a,
	output logic [13:0] adc_b,
	output logic        ad_conv,
	output logic        adc_sck,
	input  logic        adc_miso
);

	typedef enum logic [1:0] {
		IDLE,
		CONV,
		FRAME
	} state_t;

	state_t state;

	logic [capture_pkg::SCK_DIV_W-1:0] div;
	// SCK period index within the frame
	logic [capture_pkg::ADC_BIT_W-1:0] bit_cnt;
	// Per channel shift registers
	logic [capture_pkg::ADC_WIDTH-1:0] a_sh;
	logic [capture_pkg::ADC_WIDTH-1:0] b_sh;
	logic sck_edge;
	logic in_a;
	logic in_b;
	logic frame_end;

	assign sck_edge = (div == capture_pkg::SCK_DIV_LAST);

	// Which channel owns the current bit
	assign in_a = (bit_cnt >= capture_pkg::ADC_A_FIRST) && (bit_cnt <= capture_pkg::ADC_A_LAST);
	assign in_b = (bit_cnt >= capture_pkg::ADC_B_FIRST) && (bit_cnt <= capture_pkg::ADC_B_LAST);

	// Falling SCK of the last period
	assign frame_end = (state == FRAME) && sck_edge && adc_sck &&
		(bit_cnt == capture_pkg::ADC_FRAME_LAST);

	////////////////////
	// Control
	////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			state <= IDLE;
			div <= '0;
			bit_cnt <= '0;
			adc_sck <= 1'b0;
			ad_conv <= 1'b0;
			adc_done <= 1'b0;
		end else begin
			adc_done <= 1'b0;
			ad_conv <= 1'b0;
			case (state)
				IDLE: begin
					if (adc_trig) begin
						// One cycle conversion start
						ad_conv <= 1'b1;
						state <= CONV;
						div <= '0;
						bit_cnt <= '0;
						adc_sck <= 1'b0;
					end
				end
				CONV: state <= FRAME;
				FRAME: begin
					if (sck_edge) begin
						div <= '0;
						adc_sck <= ~adc_sck;
						if (frame_end) begin
							adc_done <= 1'b1;
							state <= IDLE;
						end else if (adc_sck) begin
							bit_cnt <= bit_cnt + 1'b1;
						end
					end else begin
						div <= div + 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	////////////////////
	// Data path
	////////////////////

	always_ff @(posedge CLK50MHZ) begin
		// Rising SCK, MSB first into each channel
		if (state == FRAME && sck_edge && !adc_sck) begin
			if (in_a)
				a_sh <= {a_sh[capture_pkg::ADC_WIDTH-2:0], adc_miso};
			if (in_b)
				b_sh <= {b_sh[capture_pkg::ADC_WIDTH-2:0], adc_miso};
		end
		// Both results together at frame end
		if (frame_end) begin
			adc_a <= a_sh;
			adc_b <= b_sh;
		end
	end

endmodule

// ==== logic/capture_pkg.sv ====
package capture_pkg;

	////////////////////
	// ADC
	////////////////////

	// One channel result
	localparam int ADC_WIDTH = 14;
	// Serial clocks per conversion frame
	localparam int ADC_FRAME_BITS = 34;
	localparam int ADC_BIT_W = $clog2(ADC_FRAME_BITS);
	localparam logic [ADC_BIT_W-1:0] ADC_FRAME_LAST = ADC_BIT_W'(ADC_FRAME_BITS - 1);
	// Frame layout: 2 idle, A, 2 gap, B, 2 trailing
	localparam logic [ADC_BIT_W-1:0] ADC_A_FIRST = ADC_BIT_W'(2);
	localparam logic [ADC_BIT_W-1:0] ADC_A_LAST = ADC_BIT_W'(2 + ADC_WIDTH - 1);
	localparam logic [ADC_BIT_W-1:0] ADC_B_FIRST = ADC_BIT_W'(18);
	localparam logic [ADC_BIT_W-1:0] ADC_B_LAST = ADC_BIT_W'(18 + ADC_WIDTH - 1);

	////////////////////
	// Preamp
	////////////////////

	localparam logic [3:0] GAIN_A = 4'd4;
	localparam logic [3:0] GAIN_B = 4'd2;
	localparam int GAIN_WORD_BITS = 8;
	localparam int GAIN_BIT_W = $clog2(GAIN_WORD_BITS);
	localparam logic [GAIN_BIT_W-1:0] GAIN_BIT_LAST = GAIN_BIT_W'(GAIN_WORD_BITS - 1);
	// Channel A in the high nibble, sent first
	localparam logic [GAIN_WORD_BITS-1:0] GAIN_WORD = {GAIN_A, GAIN_B};

	////////////////////
	// Timing
	////////////////////

	// Sys clocks per SCK half period
	localparam int SCK_HALF = 2;
	localparam int SCK_DIV_W = $clog2(SCK_HALF);
	localparam logic [SCK_DIV_W-1:0] SCK_DIV_LAST = SCK_DIV_W'(SCK_HALF - 1);
	// 50 MHz / 2500 = 20 kS/s
	localparam int SAMPLE_PERIOD = 2500;
	localparam int SAMPLE_CNT_W = $clog2(SAMPLE_PERIOD);
	localparam logic [SAMPLE_CNT_W-1:0] SAMPLE_LAST = SAMPLE_CNT_W'(SAMPLE_PERIOD - 1);

	////////////////////
	// LEDs and switches
	////////////////////

	localparam logic [7:0] LED_RESET = 8'haa;
	localparam logic [7:0] LED_INVALID = 8'h55;
	localparam logic [3:0] SEL_A_LO = 4'h1;
	localparam logic [3:0] SEL_A_HI = 4'h2;
	localparam logic [3:0] SEL_B_LO = 4'h4;
	localparam logic [3:0] SEL_B_HI = 4'h8;
	localparam logic [3:0] SEL_READBACK = 4'h3;

endpackage

// ==== logic/capture_top.sv ====
`timescale 1ns/1ns

module capture_top (
	input  logic       CLK50MHZ,
	input  logic       RST,
	// Board IO
	input  logic [3:0] sw,
	output logic [7:0] led,
	// Preamp pins
	output logic       amp_sck,
	output logic       amp_mosi,
	output logic       amp_cs,
	output logic       amp_shdn,
	input  logic       amp_dout,
	// ADC pins
	output logic       ad_conv,
	output logic       adc_sck,
	input  logic       adc_miso
);

	// Preamp handshake
	logic        amp_trig;
	logic        amp_done;
	logic [7:0]  amp_readback;
	// Timer
	logic        cnt_en;
	logic        adc_trig;
	// ADC handshake and results
	logic        adc_done;
	logic [13:0] adc_a;
	logic [13:0] adc_b;

	// Preamp never shut down
	assign amp_shdn = 1'b0;

	cntr cntr0 (
		.CLK50MHZ     (CLK50MHZ),
		.RST          (RST),
		.amp_trig     (amp_trig),
		.amp_done     (amp_done),
		.amp_readback (amp_readback),
		.cnt_en       (cnt_en),
		.adc_done     (adc_done),
		.adc_a        (adc_a),
		.adc_b        (adc_b),
		.sw           (sw),
		.led          (led)
	);

	sample_timer timer0 (
		.CLK50MHZ (CLK50MHZ),
		.RST      (RST),
		.cnt_en   (cnt_en),
		.cnt_trig (adc_trig)
	);

	preamp_spi preamp0 (
		.CLK50MHZ     (CLK50MHZ),
		.RST          (RST),
		.amp_trig     (amp_trig),
		.amp_done     (amp_done),
		.amp_readback (amp_readback),
		.amp_sck      (amp_sck),
		.amp_mosi     (amp_mosi),
		.amp_cs       (amp_cs),
		.amp_dout     (amp_dout)
	);

	adc_spi adc0 (
		.CLK50MHZ (CLK50MHZ),
		.RST      (RST),
		.adc_trig (adc_trig),
		.adc_done (adc_done),
		.adc_a    (adc_a),
		.adc_b    (adc_b),
		.ad_conv  (ad_conv),
		.adc_sck  (adc_sck),
		.adc_miso (adc_miso)
	);

endmodule

// ==== logic/cntr.sv ====
`timescale 1ns/1ns

module cntr (
	input  logic        CLK50MHZ,
	input  logic        RST,
	// Preamp
	output logic        amp_trig,
	input  logic        amp_done,
	input  logic [7:0]  amp_readback,
	// Sample timer
	output logic        cnt_en,
	// ADC
	input  logic        adc_done,
	input  logic [13:0] adc_a,
	input  logic [13:0] adc_b,
	// Board IO
	input  logic [3:0]  sw,
	output logic [7:0]  led
);

	typedef enum logic [1:0] {
		RESTART,
		AMP_SENDING,
		ADC_CONVERTING
	} state_t;

	state_t state;

	////////////////////
	// Sequencer
	////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			state <= RESTART;
			amp_trig <= 1'b0;
		end else begin
			amp_trig <= 1'b0;
			case (state)
				RESTART: begin
					// Single gain write after reset
					amp_trig <= 1'b1;
					state <= AMP_SENDING;
				end
				AMP_SENDING: begin
					if (amp_done)
						state <= ADC_CONVERTING;
				end
				ADC_CONVERTING: begin
					// Stays here until reset
					state <= ADC_CONVERTING;
				end
				default: state <= RESTART;
			endcase
		end
	end

	// Sampling runs once the preamp is set
	assign cnt_en = (state == ADC_CONVERTING);

	////////////////////
	// LED register
	////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			led <= capture_pkg::LED_RESET;
		end else if (adc_done) begin
			case (sw)
				capture_pkg::SEL_A_LO:
					led <= adc_a[7:0];
				// Upper six bits, zero extended
				capture_pkg::SEL_A_HI:
					led <= {2'b00, adc_a[13:8]};
				capture_pkg::SEL_B_LO:
					led <= adc_b[7:0];
				capture_pkg::SEL_B_HI:
					led <= {2'b00, adc_b[13:8]};
				capture_pkg::SEL_READBACK:
					led <= amp_readback;
				// Unused switch codes
				default:
					led <= capture_pkg::LED_INVALID;
			endcase
		end
	end

endmodule

// ==== logic/preamp_spi.sv ====
`timescale 1ns/1ns

module preamp_spi (
	input  logic       CLK50MHZ,
	input  logic       RST,
	input  logic       amp_trig,
	output logic       amp_done,
	output logic [7:0] amp_readback,
	output logic       amp_sck,
	output logic       amp_mosi,
	output logic       amp_cs,
	input  logic       amp_dout
);

	typedef enum logic [1:0] {
		IDLE,
		SHIFT,
		FINISH
	} state_t;

	state_t state;

	// SCK half period divider
	logic [capture_pkg::SCK_DIV_W-1:0] div;
	logic [capture_pkg::GAIN_BIT_W-1:0] bit_cnt;
	// Gain word out, readback in
	logic [capture_pkg::GAIN_WORD_BITS-1:0] shreg;
	// Readback bit held from rising to falling SCK
	logic din_bit;
	logic sck_edge;

	// SCK toggles on the last divider count
	assign sck_edge = (div == capture_pkg::SCK_DIV_LAST);

	// MSB first, quiet while deselected
	assign amp_mosi = shreg[capture_pkg::GAIN_WORD_BITS-1] & ~amp_cs;

	////////////////////
	// Control
	////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			state <= IDLE;
			div <= '0;
			bit_cnt <= '0;
			amp_sck <= 1'b0;
			amp_cs <= 1'b1;
			amp_done <= 1'b0;
		end else begin
			amp_done <= 1'b0;
			case (state)
				IDLE: begin
					// Trigger only honored here
					if (amp_trig) begin
						state <= SHIFT;
						amp_cs <= 1'b0;
						amp_sck <= 1'b0;
						div <= '0;
						bit_cnt <= '0;
					end
				end
				SHIFT: begin
					if (sck_edge) begin
						div <= '0;
						amp_sck <= ~amp_sck;
						// Falling SCK ends a bit
						if (amp_sck) begin
							if (bit_cnt == capture_pkg::GAIN_BIT_LAST)
								state <= FINISH;
							else
								bit_cnt <= bit_cnt + 1'b1;
						end
					end else begin
						div <= div + 1'b1;
					end
				end
				FINISH: begin
					amp_cs <= 1'b1;
					amp_done <= 1'b1;
					state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	////////////////////
	// Data path
	////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (state == IDLE && amp_trig) begin
			shreg <= capture_pkg::GAIN_WORD;
		end else if (state == SHIFT && sck_edge) begin
			// Sample on rise, shift on fall
			if (!amp_sck)
				din_bit <= amp_dout;
			else
				shreg <= {shreg[capture_pkg::GAIN_WORD_BITS-2:0], din_bit};
		end
		// Full readback byte after the 8th shift
		if (state == FINISH)
			amp_readback <= shreg;
	end

endmodule

// ==== logic/sample_timer.sv ====
`timescale 1ns/1ns

module sample_timer (
	input  logic CLK50MHZ,
	input  logic RST,
	input  logic cnt_en,
	output logic cnt_trig
);

	// Period counter
	logic [capture_pkg::SAMPLE_CNT_W-1:0] cnt;

	////////////////////
	// Trigger generation
	////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			cnt <= '0;
			cnt_trig <= 1'b0;
		end else if (!cnt_en) begin
			// Held at zero so phase starts at enable
			cnt <= '0;
			cnt_trig <= 1'b0;
		end else if (cnt == capture_pkg::SAMPLE_LAST) begin
			// Wrap, one trigger pulse
			cnt <= '0;
			cnt_trig <= 1'b1;
		end else begin
			cnt <= cnt + 1'b1;
			cnt_trig <= 1'b0;
		end
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build the capture testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_capture -f vlog.f -o sim_capture \
	|| { echo "Verilator build failed"; exit 1; }
out=$(./obj_dir/sim_capture)
echo "$out"
echo "$out" | grep -q "Finished with no errors" && exit 0 || exit 1

// ==== sim/spi_part_models.sv ====
`timescale 1ns/1ns

////////////////////
// Preamp model
////////////////////

module preamp_model #(
	parameter logic [7:0] INIT_REG = 8'h00
) (
	input  logic       amp_sck,
	input  logic       amp_mosi,
	input  logic       amp_cs,
	output logic       amp_dout,
	output logic [7:0] rx_word,
	output int         rx_bits,
	output int         xfer_count
);

	// Gain register, shifted out as the readback
	logic [7:0] gain_reg;
	logic [7:0] out_sh;
	logic [7:0] in_sh;
	int bit_count;
	logic xfer_end;

	assign amp_dout = out_sh[7];

	initial begin
		gain_reg = INIT_REG;
		out_sh = '0;
		in_sh = '0;
		rx_word = '0;
		rx_bits = 0;
		xfer_count = 0;
		forever begin
			@(negedge amp_cs);
			out_sh = gain_reg;
			in_sh = '0;
			bit_count = 0;
			xfer_end = 1'b0;
			while (!xfer_end) begin
				@(amp_sck or amp_cs);
				if (amp_cs === 1'b1) begin
					xfer_end = 1'b1;
				end else if (amp_sck === 1'b1) begin
					// Rising SCK, take MOSI
					in_sh = {in_sh[6:0], amp_mosi};
					bit_count++;
				end else begin
					out_sh = {out_sh[6:0], 1'b0};
				end
			end
			// New word replaces the register on deselect
			rx_word = in_sh;
			rx_bits = bit_count;
			gain_reg = in_sh;
			xfer_count++;
		end
	end

endmodule

////////////////////
// ADC model
////////////////////

module adc_model #(
	parameter logic [31:0] SEED = 32'h1
) (
	input  logic        ad_conv,
	input  logic        adc_sck,
	output logic        adc_miso,
	output logic [13:0] sent_a,
	output logic [13:0] sent_b,
	output int          conv_count
);

	logic [31:0] lfsr;
	logic [capture_pkg::ADC_FRAME_BITS-1:0] frame;
	logic [capture_pkg::ADC_WIDTH-1:0] a_val;
	logic [capture_pkg::ADC_WIDTH-1:0] b_val;

	// Galois form, output bit is the LSB
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0])
			n = n ^ 32'ha3000000;
		return n;
	endfunction

	// First bit of the frame sits in the MSB
	assign adc_miso = frame[capture_pkg::ADC_FRAME_BITS-1];

	initial begin
		lfsr = SEED;
		frame = '0;
		sent_a = '0;
		sent_b = '0;
		conv_count = 0;
		forever begin
			@(posedge ad_conv);
			for (int i = 0; i < capture_pkg::ADC_WIDTH; i++) begin
				a_val = {a_val[capture_pkg::ADC_WIDTH-2:0], lfsr[0]};
				lfsr = lfsr_step(lfsr);
			end
			for (int i = 0; i < capture_pkg::ADC_WIDTH; i++) begin
				b_val = {b_val[capture_pkg::ADC_WIDTH-2:0], lfsr[0]};
				lfsr = lfsr_step(lfsr);
			end
			sent_a = a_val;
			sent_b = b_val;
			conv_count++;
			// 2 idle, A, 2 gap, B, 2 trailing
			frame = {2'b00, a_val, 2'b00, b_val, 2'b00};
			// Next bit on each falling SCK
			repeat (capture_pkg::ADC_FRAME_BITS) begin
				@(negedge adc_sck);
				frame = frame << 1;
			end
		end
	end

endmodule

// ==== sim/tb_capture.sv ====
`timescale 1ns/1ns

module tb_capture;

	localparam int CLK_PERIOD = 20;
	// Six conversions in the tests, plus first period and margin
	localparam int N_CONV = 6;
	localparam int WATCHDOG_NS = (N_CONV + 2) * capture_pkg::SAMPLE_PERIOD * CLK_PERIOD;
	localparam logic [7:0] READBACK_SEED = 8'h11;
	localparam logic [31:0] LFSR_SEED = 32'h7eaacb49;

	logic CLK50MHZ;
	logic RST;
	logic [3:0] sw;
	logic [7:0] led;
	logic amp_sck;
	logic amp_mosi;
	logic amp_cs;
	logic amp_shdn;
	logic amp_dout;
	logic ad_conv;
	logic adc_sck;
	logic adc_miso;
	// Model side records
	logic [7:0] amp_word;
	int amp_bits;
	int amp_xfers;
	logic [13:0] sent_a;
	logic [13:0] sent_b;
	int sent_count;
	// Bookkeeping
	int cycle = 0;
	int conv_cycles[$];
	logic shdn_high;
	int errors;
	int test_errors;
	int tests_run;
	int tests_failed;

	capture_top dut0 (
		.CLK50MHZ (CLK50MHZ),
		.RST      (RST),
		.sw       (sw),
		.led      (led),
		.amp_sck  (amp_sck),
		.amp_mosi (amp_mosi),
		.amp_cs   (amp_cs),
		.amp_shdn (amp_shdn),
		.amp_dout (amp_dout),
		.ad_conv  (ad_conv),
		.adc_sck  (adc_sck),
		.adc_miso (adc_miso)
	);

	preamp_model #(.INIT_REG(READBACK_SEED)) amp_part (
		.amp_sck    (amp_sck),
		.amp_mosi   (amp_mosi),
		.amp_cs     (amp_cs),
		.amp_dout   (amp_dout),
		.rx_word    (amp_word),
		.rx_bits    (amp_bits),
		.xfer_count (amp_xfers)
	);

	adc_model #(.SEED(LFSR_SEED)) adc_part (
		.ad_conv    (ad_conv),
		.adc_sck    (adc_sck),
		.adc_miso   (adc_miso),
		.sent_a     (sent_a),
		.sent_b     (sent_b),
		.conv_count (sent_count)
	);

	always #(CLK_PERIOD / 2) CLK50MHZ = ~CLK50MHZ;

	always @(posedge CLK50MHZ) cycle <= cycle + 1;

	// Conversion start times and shutdown pin, sampled mid cycle
	always @(negedge CLK50MHZ) begin
		if (ad_conv === 1'b1)
			conv_cycles.push_back(cycle);
		if (!RST && amp_shdn !== 1'b0)
			shdn_high = 1'b1;
	end

	////////////////////
	// Helpers
	////////////////////

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("[FAIL] %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
			test_errors++;
		end
	endtask

	task automatic report_test(input string name);
		tests_run++;
		errors += test_errors;
		if (test_errors != 0)
			tests_failed++;
		$display("%s: %s, %0d errors", name, (test_errors == 0) ? "ok" : "failed", test_errors);
		test_errors = 0;
	endtask

	// Done pulse, then one more cycle for the LED register
	task automatic run_conversion(input logic [3:0] sel);
		int waited;
		@(negedge CLK50MHZ);
		sw = sel;
		waited = 0;
		do begin
			@(negedge CLK50MHZ);
			waited++;
		end while (dut0.adc_done !== 1'b1 && waited < capture_pkg::SAMPLE_PERIOD + 200);
		if (dut0.adc_done !== 1'b1) begin
			$display("Timed out after %0d cycles waiting for a conversion to finish", waited);
			test_errors++;
		end
		@(negedge CLK50MHZ);
	endtask

	////////////////////
	// Tests
	////////////////////

	task automatic reset_state_test();
		int waited;
		int xfer_end;
		check_value("led after reset", led, 8'haa);
		check_value("amp_cs after reset", amp_cs, 1'b1);
		waited = 0;
		while (amp_xfers == 0 && waited < 200) begin
			@(negedge CLK50MHZ);
			waited++;
		end
		if (amp_xfers == 0) begin
			$display("Timed out waiting for the preamp transfer to end");
			test_errors++;
		end
		xfer_end = cycle;
		// No conversion before the gain write is done
		check_value("ad_conv pulses before gain write", conv_cycles.size(), 0);
		// Sample timer only starts once the transfer has ended
		waited = 0;
		while (conv_cycles.size() == 0 && waited < capture_pkg::SAMPLE_PERIOD + 200) begin
			@(negedge CLK50MHZ);
			waited++;
		end
		if (conv_cycles.size() == 0) begin
			$display("Timed out waiting for the first ad_conv pulse");
			test_errors++;
		end else begin
			assert (conv_cycles[0] - xfer_end >= capture_pkg::SAMPLE_PERIOD) else begin
				$display("[FAIL] %0t ns: first ad_conv %0d cycles after gain write, expected %0d or more",
					$time, conv_cycles[0] - xfer_end, capture_pkg::SAMPLE_PERIOD);
				test_errors++;
			end
		end
		report_test("reset_state");
	endtask

	task automatic gain_write_test();
		// A gain in the high nibble, sent first
		check_value("preamp word", amp_word, 8'h42);
		check_value("preamp bits", amp_bits, 8);
		check_value("preamp transfers", amp_xfers, 1);
		check_value("amp_shdn went high", shdn_high, 1'b0);
		report_test("gain_write");
	endtask

	task automatic readback_test();
		run_conversion(capture_pkg::SEL_READBACK);
		check_value("led for readback", led, READBACK_SEED);
		report_test("readback");
	endtask

	task automatic adc_slice_test();
		run_conversion(capture_pkg::SEL_A_LO);
		check_value("led for A low", led, sent_a[7:0]);
		run_conversion(capture_pkg::SEL_A_HI);
		check_value("led for A high", led, {2'b00, sent_a[13:8]});
		run_conversion(capture_pkg::SEL_B_LO);
		check_value("led for B low", led, sent_b[7:0]);
		run_conversion(capture_pkg::SEL_B_HI);
		check_value("led for B high", led, {2'b00, sent_b[13:8]});
		report_test("adc_slices");
	endtask

	task automatic invalid_switch_test();
		run_conversion(4'hf);
		check_value("led for invalid switch", led, 8'h55);
		report_test("invalid_switch");
	endtask

	task automatic conv_spacing_test();
		if (conv_cycles.size() < 3) begin
			$display("Only %0d ad_conv pulses seen, three are needed", conv_cycles.size());
			test_errors++;
		end
		for (int i = 1; i < conv_cycles.size(); i++)
			check_value("ad_conv spacing", conv_cycles[i] - conv_cycles[i-1],
				capture_pkg::SAMPLE_PERIOD);
		// One frame per conversion the tests waited for
		check_value("frames sent by the ADC model", sent_count, N_CONV);
		report_test("conv_spacing");
	endtask

	////////////////////
	// Run
	////////////////////

	initial begin
		CLK50MHZ = 1'b0;
		RST = 1'b1;
		sw = 4'h0;
		shdn_high = 1'b0;
		errors = 0;
		test_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		repeat (3) @(posedge CLK50MHZ);
		@(negedge CLK50MHZ);
		RST = 1'b0;
		reset_state_test();
		gain_write_test();
		readback_test();
		adc_slice_test();
		invalid_switch_test();
		conv_spacing_test();
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	// Watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("Run timed out after %0d ns before all tests finished", WATCHDOG_NS);
		$display("Finished with errors");
		$finish;
	end

endmodule

// ==== vlog.f ====
logic/capture_pkg.sv
logic/sample_timer.sv
logic/preamp_spi.sv
logic/adc_spi.sv
logic/cntr.sv
logic/capture_top.sv
sim/spi_part_models.sv
sim/tb_capture.sv
